//--- axi_pkg.sv
package axi_pkg;

    // ########################################
    // Read channel widths
    // ########################################
    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 64;
    localparam int axi_resp_w = 2;

    localparam logic [axi_resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [axi_resp_w-1:0] resp_exokay = 2'b01;
    localparam logic [axi_resp_w-1:0] resp_slverr = 2'b10;
    localparam logic [axi_resp_w-1:0] resp_decerr = 2'b11;

    // ########################################
    // Fixed AR attributes for single beats
    // ########################################
    localparam logic [3:0] ar_id    = 4'd0;
    localparam logic [7:0] ar_len   = 8'd0;     // One beat per burst.
    localparam logic [2:0] ar_size  = 3'd3;     // 8 bytes per beat.
    localparam logic [1:0] ar_burst = 2'b01;    // INCR.

endpackage

//--- fetch_pkg.sv
package fetch_pkg;

    // ########################################
    // Core fetch parameters
    // ########################################
    localparam int xlen = 32;

    // First address fetched after reset.
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    localparam logic [xlen-1:0] inst_bytes = 32'd4;     // No compressed instructions.

    // A 64-bit beat holds two instructions; this bit of the pc picks
    // the upper one.
    localparam int beat_offset_bit = 2;

endpackage

//--- pc_gen.sv
module pc_gen (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       redirect_valid,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,

    output logic                       fetch_valid,
    output logic [fetch_pkg::xlen-1:0] fetch_pc,
    input  logic                       fetch_ready
);

    import fetch_pkg::*;

    logic            run_q;         // Set on the first edge out of reset.
    logic [xlen-1:0] pc_q;
    logic            fetch_fire;

    // A redirect cycle never issues a request from the stale pc.
    assign fetch_valid = run_q & ~redirect_valid;
    assign fetch_pc    = pc_q;
    assign fetch_fire  = fetch_valid & fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // ########################################
    // Next fetch address
    // ########################################
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= reset_pc;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;                // Redirect always wins.
        end else if (fetch_fire) begin
            pc_q <= pc_q + inst_bytes;
        end
    end

endmodule

//--- ifu.sv
module ifu (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           req_valid,
    input  logic [fetch_pkg::xlen-1:0]     req_addr,
    output logic                           req_ready,

    output logic                           resp_valid,
    output logic [axi_pkg::axi_data_w-1:0] resp_data,
    output logic                           resp_err,
    input  logic                           resp_ready,

    input  logic                           flush,

    output logic [axi_pkg::axi_addr_w-1:0] ifu_axi_araddr,
    output logic                           ifu_axi_arvalid,
    input  logic                           ifu_axi_arready,
    input  logic [axi_pkg::axi_data_w-1:0] ifu_axi_rdata,
    input  logic [axi_pkg::axi_resp_w-1:0] ifu_axi_rresp,
    input  logic                           ifu_axi_rlast,
    input  logic                           ifu_axi_rvalid,
    output logic                           ifu_axi_rready
);

    import axi_pkg::*;

    localparam int beat_lsb = $clog2(axi_data_w / 8);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp
    } state_t;

    state_t                state_q;
    state_t                state_d;
    logic                  drop_q;      // Outstanding read was flushed.
    logic [axi_addr_w-1:0] addr_q;
    logic [axi_data_w-1:0] data_q;
    logic                  err_q;

    logic req_fire;
    logic ar_fire;
    logic r_fire;
    logic r_done;
    logic resp_fire;
    logic beat_err;

    assign req_ready = (state_q == st_idle) | ((state_q == st_resp) & resp_ready);
    assign req_fire  = req_valid & req_ready;
    assign ar_fire   = ifu_axi_arvalid & ifu_axi_arready;
    assign r_fire    = ifu_axi_rvalid & ifu_axi_rready;
    assign r_done    = r_fire & ifu_axi_rlast;
    assign resp_fire = resp_valid & resp_ready;

    // EXOKAY counts as success as well.
    assign beat_err = ~((ifu_axi_rresp == resp_okay) | (ifu_axi_rresp == resp_exokay));

    assign ifu_axi_arvalid = (state_q == st_addr);
    assign ifu_axi_araddr  = addr_q;
    assign ifu_axi_rready  = (state_q == st_data);

    assign resp_valid = (state_q == st_resp);
    assign resp_data  = data_q;
    assign resp_err   = err_q;

    // ########################################
    // Read FSM
    // ########################################
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req_fire) begin
                    state_d = st_addr;
                end
            end
            st_addr: begin
                if (ar_fire) begin
                    state_d = st_data;
                end
            end
            st_data: begin
                if (r_done) begin
                    state_d = (drop_q | flush) ? st_idle : st_resp;
                end
            end
            st_resp: begin
                if (flush) begin
                    state_d = st_idle;          // Buffered beat is discarded.
                end else if (req_fire) begin
                    state_d = st_addr;          // Back to back with the handoff.
                end else if (resp_fire) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (r_done) begin
                drop_q <= 1'b0;
            end else if (flush & ((state_q == st_addr) | (state_q == st_data))) begin
                drop_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= {req_addr[axi_addr_w-1:beat_lsb], {beat_lsb{1'b0}}};
        end
        if (r_fire) begin
            data_q <= ifu_axi_rdata;
            err_q  <= beat_err;
        end
    end

endmodule

//--- if_id_reg.sv
module if_id_reg (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           fetch_valid,
    input  logic [fetch_pkg::xlen-1:0]     fetch_pc,
    output logic                           fetch_ready,

    input  logic                           redirect_valid,

    output logic                           id_valid,
    output logic [fetch_pkg::xlen-1:0]     id_pc,
    output logic [fetch_pkg::xlen-1:0]     id_inst,
    output logic                           id_fault,
    input  logic                           id_ready,
    input  logic                           id_stall,

    output logic [axi_pkg::axi_addr_w-1:0] ifu_axi_araddr,
    output logic                           ifu_axi_arvalid,
    input  logic                           ifu_axi_arready,
    input  logic [axi_pkg::axi_data_w-1:0] ifu_axi_rdata,
    input  logic [axi_pkg::axi_resp_w-1:0] ifu_axi_rresp,
    input  logic                           ifu_axi_rlast,
    input  logic                           ifu_axi_rvalid,
    output logic                           ifu_axi_rready
);

    import fetch_pkg::*;

    logic                  req_ready;
    logic                  resp_valid;
    logic [2*xlen-1:0]     resp_data;
    logic                  resp_err;
    logic                  resp_ready;

    logic [xlen-1:0] flight_pc_q;       // Pc of the read held by the ifu.
    logic            out_valid_q;
    logic [xlen-1:0] out_pc_q;
    logic [xlen-1:0] out_inst_q;
    logic            out_fault_q;

    logic fetch_fire;
    logic take;
    logic resp_fire;

    assign fetch_ready = req_ready;
    assign fetch_fire  = fetch_valid & req_ready;
    assign take        = out_valid_q & id_ready & ~id_stall;
    assign resp_ready  = ~redirect_valid & (~out_valid_q | take);
    assign resp_fire   = resp_valid & resp_ready;

    assign id_valid = out_valid_q;
    assign id_pc    = out_pc_q;
    assign id_inst  = out_inst_q;
    assign id_fault = out_fault_q;

    // ########################################
    // Output register
    // ########################################
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (redirect_valid) begin
            out_valid_q <= 1'b0;                // Wrong path is dropped.
        end else if (resp_fire) begin
            out_valid_q <= 1'b1;
        end else if (take) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            flight_pc_q <= fetch_pc;
        end
        if (resp_fire) begin
            out_pc_q    <= flight_pc_q;
            out_inst_q  <= flight_pc_q[beat_offset_bit] ? resp_data[2*xlen-1:xlen]
                                                        : resp_data[xlen-1:0];
            out_fault_q <= resp_err;
        end
    end

    ifu ifu_i (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (fetch_valid),
        .req_addr        (fetch_pc),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp_data       (resp_data),
        .resp_err        (resp_err),
        .resp_ready      (resp_ready),
        .flush           (redirect_valid),
        .ifu_axi_araddr  (ifu_axi_araddr),
        .ifu_axi_arvalid (ifu_axi_arvalid),
        .ifu_axi_arready (ifu_axi_arready),
        .ifu_axi_rdata   (ifu_axi_rdata),
        .ifu_axi_rresp   (ifu_axi_rresp),
        .ifu_axi_rlast   (ifu_axi_rlast),
        .ifu_axi_rvalid  (ifu_axi_rvalid),
        .ifu_axi_rready  (ifu_axi_rready)
    );

endmodule

//--- fetch_top.sv
module fetch_top (
    input  logic                           clk,
    input  logic                           rst,

    // Decode side.
    output logic                           id_valid,
    output logic [fetch_pkg::xlen-1:0]     id_pc,
    output logic [fetch_pkg::xlen-1:0]     id_inst,
    output logic                           id_fault,
    input  logic                           id_ready,
    input  logic                           id_stall,

    // Redirect from branch and jump resolution.
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]     redirect_pc,

    // AXI read channels.
    output logic [axi_pkg::axi_addr_w-1:0] ifu_axi_araddr,
    output logic                           ifu_axi_arvalid,
    input  logic                           ifu_axi_arready,
    input  logic [axi_pkg::axi_data_w-1:0] ifu_axi_rdata,
    input  logic [axi_pkg::axi_resp_w-1:0] ifu_axi_rresp,
    input  logic                           ifu_axi_rlast,
    input  logic                           ifu_axi_rvalid,
    output logic                           ifu_axi_rready
);

    import fetch_pkg::*;

    logic            fetch_valid;
    logic [xlen-1:0] fetch_pc;
    logic            fetch_ready;

    // ########################################
    // Program counter
    // ########################################
    pc_gen pc_gen_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_ready    (fetch_ready)
    );

    // ########################################
    // IF/ID register with the AXI fetch unit
    // ########################################
    if_id_reg if_id_reg_i (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .fetch_ready     (fetch_ready),
        .redirect_valid  (redirect_valid),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_inst         (id_inst),
        .id_fault        (id_fault),
        .id_ready        (id_ready),
        .id_stall        (id_stall),
        .ifu_axi_araddr  (ifu_axi_araddr),
        .ifu_axi_arvalid (ifu_axi_arvalid),
        .ifu_axi_arready (ifu_axi_arready),
        .ifu_axi_rdata   (ifu_axi_rdata),
        .ifu_axi_rresp   (ifu_axi_rresp),
        .ifu_axi_rlast   (ifu_axi_rlast),
        .ifu_axi_rvalid  (ifu_axi_rvalid),
        .ifu_axi_rready  (ifu_axi_rready)
    );

endmodule

//--- axi_mem_model.sv
module axi_mem_model (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [axi_pkg::axi_addr_w-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [axi_pkg::axi_data_w-1:0] rdata,
    output logic [axi_pkg::axi_resp_w-1:0] rresp,
    output logic                           rlast,
    output logic                           rvalid,
    input  logic                           rready
);

    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;

    localparam int beat_bytes = 1 << ar_size;
    localparam logic [31:0] word_key = 32'h1357_9bdf;

    logic                  data_phase_q = 1'b0;     // Low while waiting for an address.
    int unsigned           delay_q = 0;             // Cycles left before the next ready or valid.
    logic [axi_addr_w-1:0] base_q = '0;
    logic                  err_q = 1'b0;

    function automatic logic [31:0] word_at(input logic [axi_addr_w-1:0] addr);
        return addr ^ word_key;
    endfunction

    assign arready = ~data_phase_q && (delay_q == 0);
    assign rvalid  = data_phase_q && (delay_q == 0);
    assign rlast   = rvalid;                        // Every burst is a single beat.
    assign rdata   = {word_at(base_q + 32'd4), word_at(base_q)};
    assign rresp   = err_q ? resp_slverr : resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_phase_q <= 1'b0;
            delay_q      <= $urandom_range(3, 0);
            base_q       <= '0;
            err_q        <= 1'b0;
        end else if (!data_phase_q) begin
            if (arvalid && delay_q == 0) begin
                base_q       <= araddr & ~(axi_addr_w'(beat_bytes - 1));
                err_q        <= araddr[20];         // Bit 20 selects the faulting region.
                delay_q      <= $urandom_range(5, 0);
                data_phase_q <= 1'b1;
            end else if (arvalid) begin
                delay_q <= delay_q - 1;
            end
        end else begin
            if (delay_q != 0) begin
                delay_q <= delay_q - 1;
            end else if (rready) begin
                delay_q      <= $urandom_range(3, 0);
                data_phase_q <= 1'b0;
            end
        end
    end

endmodule

//--- tb_fetch_top.sv
module tb_fetch_top;

    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;
    import fetch_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int beat_bytes = 1 << ar_size;
    localparam logic [xlen-1:0] word_key = 32'h1357_9bdf;

    logic                  clk;
    logic                  rst;
    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    logic [xlen-1:0]       id_inst;
    logic                  id_fault;
    logic                  id_ready;
    logic                  id_stall;
    logic                  redirect_valid;
    logic [xlen-1:0]       redirect_pc;
    logic [axi_addr_w-1:0] ifu_axi_araddr;
    logic                  ifu_axi_arvalid;
    logic                  ifu_axi_arready;
    logic [axi_data_w-1:0] ifu_axi_rdata;
    logic [axi_resp_w-1:0] ifu_axi_rresp;
    logic                  ifu_axi_rlast;
    logic                  ifu_axi_rvalid;
    logic                  ifu_axi_rready;

    logic [xlen-1:0]       exp_pc;                  // Pc that decode should see next.

    logic [axi_addr_w-1:0] ar_addr_q;               // Address offered in the previous cycle.
    logic                  ar_wait_q;               // AR was offered and not yet accepted.

    fetch_top fetch_top_i (
        .clk (clk), .rst (rst),
        .id_valid (id_valid), .id_pc (id_pc), .id_inst (id_inst), .id_fault (id_fault),
        .id_ready (id_ready), .id_stall (id_stall),
        .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
        .ifu_axi_araddr (ifu_axi_araddr), .ifu_axi_arvalid (ifu_axi_arvalid),
        .ifu_axi_arready (ifu_axi_arready), .ifu_axi_rdata (ifu_axi_rdata),
        .ifu_axi_rresp (ifu_axi_rresp), .ifu_axi_rlast (ifu_axi_rlast),
        .ifu_axi_rvalid (ifu_axi_rvalid), .ifu_axi_rready (ifu_axi_rready)
    );

    axi_mem_model axi_mem_model_i (
        .clk (clk), .rst (rst),
        .araddr (ifu_axi_araddr), .arvalid (ifu_axi_arvalid), .arready (ifu_axi_arready),
        .rdata (ifu_axi_rdata), .rresp (ifu_axi_rresp), .rlast (ifu_axi_rlast),
        .rvalid (ifu_axi_rvalid), .rready (ifu_axi_rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ########################################
    // Checking and reference model
    // ########################################
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error in %s: %s expected %h actual %h",
                               test, what, expected, actual));
        end
    endtask

    function automatic logic [xlen-1:0] expected_inst(input logic [xlen-1:0] pc);
        return pc ^ word_key;
    endfunction

    // The AR address is beat aligned and holds still until arready.
    always @(posedge clk) begin
        if (rst) begin
            ar_wait_q <= 1'b0;
        end else begin
            if (ar_wait_q) begin
                check_value("ar_monitor", "arvalid held", xlen'(1), xlen'(ifu_axi_arvalid));
                check_value("ar_monitor", "araddr held", ar_addr_q, ifu_axi_araddr);
            end
            if (ifu_axi_arvalid) begin
                check_value("ar_monitor", "araddr beat offset", '0,
                            xlen'(ifu_axi_araddr % beat_bytes));
            end
            ar_wait_q <= ifu_axi_arvalid && !ifu_axi_arready;
            ar_addr_q <= ifu_axi_araddr;
        end
    end

    // Called on a clock edge, before any input is driven for the next cycle.
    task automatic note_take(input string test, output bit took);
        took = id_valid && id_ready && !id_stall;
        if (took) begin
            check_value(test, "pc", exp_pc, id_pc);
            check_value(test, "inst", expected_inst(exp_pc), id_inst);
            check_value(test, "fault", xlen'(exp_pc[20]), xlen'(id_fault));
            exp_pc = exp_pc + inst_bytes;
        end
    endtask

    task automatic receive(input string test, input int count, input bit jitter);
        int  got;
        int  idle;
        bit  took;
        got  = 0;
        idle = 0;
        id_ready <= 1'b1;
        id_stall <= 1'b0;
        while (got < count) begin
            @(posedge clk);
            note_take(test, took);
            if (took) begin
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) begin
                    stop_run($sformatf("%s timed out: no instruction reached decode in %0d cycles",
                                       test, timeout_cycles));
                end
            end
            if (got == count) begin
                id_ready <= 1'b0;               // Nothing is taken after the last check.
                id_stall <= 1'b0;
            end else if (jitter) begin
                id_ready <= ($urandom_range(1, 0) == 1);
                id_stall <= ($urandom_range(3, 0) == 0);
            end
        end
    endtask

    task automatic redirect_to(input logic [xlen-1:0] target);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        id_ready       <= 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
        exp_pc = target;
    endtask

    // An address still waiting for arready, or an R beat still pending,
    // keeps the read outstanding through the following cycle.
    task automatic redirect_when_busy(input string test, input logic [xlen-1:0] target);
        int waited;
        bit took;
        bit busy;
        waited = 0;
        busy   = 1'b0;
        id_ready <= 1'b1;
        id_stall <= 1'b0;
        while (!busy) begin
            @(posedge clk);
            note_take(test, took);
            busy = ifu_axi_arvalid || (ifu_axi_rready && !ifu_axi_rvalid);
            if (!busy) begin
                waited++;
                if (waited > timeout_cycles) begin
                    stop_run($sformatf("%s timed out: no AXI read seen in %0d cycles",
                                       test, timeout_cycles));
                end
            end
        end
        redirect_to(target);
        check_value(test, "read outstanding", xlen'(1), xlen'(ifu_axi_arvalid | ifu_axi_rready));
    endtask

    // ########################################
    // Directed tests
    // ########################################
    task automatic reset_state();
        @(posedge clk);
        check_value("reset_state", "id_valid", '0, xlen'(id_valid));
        check_value("reset_state", "arvalid", '0, xlen'(ifu_axi_arvalid));
        check_value("reset_state", "rready", '0, xlen'(ifu_axi_rready));
        receive("reset_state", 1, 1'b0);
    endtask

    task automatic redirect_in_flight();
        for (int round = 0; round < 4; round++) begin
            redirect_when_busy("redirect_in_flight", 32'h8000_4000 + xlen'(round) * 32'h104);
            receive("redirect_in_flight", 5, 1'b0);
        end
    endtask

    task automatic fault_region();
        redirect_to(32'h8010_0008);
        receive("fault_region", 8, 1'b1);
        redirect_to(32'h8000_6000);
        receive("fault_region", 8, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hc0d1_9964));
        rst            <= 1'b1;
        id_ready       <= 1'b0;
        id_stall       <= 1'b0;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        exp_pc          = reset_pc;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        reset_state();
        receive("sequential_stream", 40, 1'b0);
        receive("back_pressure", 60, 1'b1);
        redirect_to(32'h8000_1234);             // Odd word, upper half of its beat.
        receive("redirect_odd_word", 6, 1'b0);
        redirect_in_flight();
        fault_region();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog.f
axi_pkg.sv
fetch_pkg.sv
pc_gen.sv
ifu.sv
if_id_reg.sv
fetch_top.sv
axi_mem_model.sv
tb_fetch_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch_top \
    --Mdir "$build_dir" -o tb_fetch_top -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_fetch_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
